/* design/sound_defs.svh */
// Sound block constants: channel count, register map and bus widths.
`ifndef SOUND_DEFS_SVH
`define SOUND_DEFS_SVH

// Number of square-wave tone channels.
`define SND_NUM_CHANNELS 4

// Bus widths.
`define SND_ADDR_WIDTH  7
`define SND_BYTE_WIDTH  8
`define SND_WORD_WIDTH  16
`define SND_LEVEL_WIDTH 3

// Register map, as word indices on the 16-bit bus.
`define SND_REG_CTRL      0
`define SND_REG_PRESCALE  1
`define SND_REG_HALF_BASE 2

`endif

/* design/sound_pkg.sv */
// Shared types and register-index helpers for the sound block.
`include "sound_defs.svh"

package sound_pkg;

  // Data and address vectors.
  typedef logic [`SND_BYTE_WIDTH-1:0]   byte_t;
  typedef logic [`SND_ADDR_WIDTH-1:0]   byte_addr_t;
  typedef logic [`SND_ADDR_WIDTH-2:0]   word_addr_t;
  typedef logic [`SND_WORD_WIDTH-1:0]   reg_word_t;
  typedef logic [1:0]                   byte_en_t;
  // Channel sum, 0 up to the channel count.
  typedef logic [`SND_LEVEL_WIDTH-1:0]  mix_level_t;

  // One request on the register bus.
  typedef struct packed {
    logic       rd;
    logic       wr;
    byte_en_t   be;
    word_addr_t addr;
    reg_word_t  wdata;
  } bus_req_t;

  // SPI slave framing state.
  typedef enum logic [1:0] {IDLE, CMD, DATA} spi_state_t;

  // True for the half-period word of any channel.
  function automatic logic is_half_reg(word_addr_t addr);
    return (int'(addr) >= `SND_REG_HALF_BASE) &&
           (int'(addr) < `SND_REG_HALF_BASE + `SND_NUM_CHANNELS);
  endfunction

  // Channel number of a half-period word.
  function automatic logic [$clog2(`SND_NUM_CHANNELS)-1:0] half_index(word_addr_t addr);
    word_addr_t offset;
    offset = addr - word_addr_t'(`SND_REG_HALF_BASE);
    return offset[$clog2(`SND_NUM_CHANNELS)-1:0];
  endfunction

endpackage

/* design/spi_mem_slave.sv */
// Mode-0 SPI memory slave: command byte, then auto-incrementing byte reads or writes.
`timescale 1ns/1ps

module spi_mem_slave (
  input  logic                  clk,
  input  logic                  _reset,
  input  logic                  _select,
  input  logic                  sck,
  input  logic                  mosi,
  output logic                  miso,
  output logic                  byte_rd,
  output logic                  byte_wr,
  output sound_pkg::byte_addr_t byte_addr,
  output sound_pkg::byte_t      byte_wdata,
  input  sound_pkg::byte_t      byte_rdata
);

  //////////////////////////////////////////////////////////////////////
  // Pin synchronisation and sck edge detection.
  //////////////////////////////////////////////////////////////////////
  logic [2:0] sck_pipe;
  logic [1:0] mosi_pipe;
  logic [1:0] sel_pipe;

  always_ff @(posedge clk) begin
    if (!_reset) begin
      sck_pipe  <= '0;
      mosi_pipe <= '0;
      // Deselected while in reset.
      sel_pipe  <= '1;
    end else begin
      sck_pipe  <= {sck_pipe[1:0], sck};
      mosi_pipe <= {mosi_pipe[0], mosi};
      sel_pipe  <= {sel_pipe[0], _select};
    end
  end

  logic selected;
  logic sck_rise;
  logic sck_fall;
  assign selected = ~sel_pipe[1];
  assign sck_rise = selected & sck_pipe[1] & ~sck_pipe[2];
  assign sck_fall = selected & ~sck_pipe[1] & sck_pipe[2];

  //////////////////////////////////////////////////////////////////////
  // Framing FSM.
  //////////////////////////////////////////////////////////////////////
  sound_pkg::spi_state_t state;
  logic [2:0]            bit_cnt;
  logic                  is_write;
  logic                  rd_wait;
  logic                  miso_q;
  sound_pkg::byte_t      rx_shift;
  sound_pkg::byte_t      rx_byte;
  sound_pkg::byte_t      tx_shift;
  sound_pkg::byte_addr_t addr;
  logic                  byte_done;

  // Incoming byte including the bit sampled on this edge.
  assign rx_byte   = {rx_shift[6:0], mosi_pipe[1]};
  assign byte_done = sck_rise & (bit_cnt == 3'd7);

  always_ff @(posedge clk) begin
    if (!_reset) begin
      state    <= sound_pkg::IDLE;
      bit_cnt  <= '0;
      is_write <= 1'b0;
      byte_rd  <= 1'b0;
      byte_wr  <= 1'b0;
      rd_wait  <= 1'b0;
      miso_q   <= 1'b0;
    end else begin
      byte_rd <= 1'b0;
      byte_wr <= 1'b0;
      // Read data arrives one cycle after the strobe.
      rd_wait <= byte_rd;
      if (!selected) begin
        state   <= sound_pkg::IDLE;
        bit_cnt <= '0;
        miso_q  <= 1'b0;
      end else begin
        if (state == sound_pkg::IDLE)
          state <= sound_pkg::CMD;
        // Mode 0: drive the next bit on the falling edge.
        if (sck_fall)
          miso_q <= tx_shift[7];
        if (sck_rise)
          bit_cnt <= bit_cnt + 3'd1;
        if (byte_done) begin
          if (state != sound_pkg::DATA) begin
            // Command byte. Reads fetch the first byte at once.
            is_write <= rx_byte[7];
            byte_rd  <= ~rx_byte[7];
            state    <= sound_pkg::DATA;
          end else if (is_write) begin
            byte_wr <= 1'b1;
          end else begin
            byte_rd <= 1'b1;
          end
        end
      end
    end
  end

  // Shift registers and address pointer.
  always_ff @(posedge clk) begin
    if (sck_rise)
      rx_shift <= rx_byte;
    if (!selected)
      tx_shift <= '0;
    else if (rd_wait)
      tx_shift <= byte_rdata;
    else if (sck_fall)
      tx_shift <= {tx_shift[6:0], 1'b0};
    if (byte_done) begin
      if (state != sound_pkg::DATA) begin
        byte_addr <= rx_byte[6:0];
        // addr always holds the next byte to access.
        addr      <= rx_byte[6:0] + {6'd0, ~rx_byte[7]};
      end else begin
        byte_addr  <= addr;
        byte_wdata <= rx_byte;
        addr       <= addr + 7'd1;
      end
    end
  end

  // Output only while the host selects us.
  assign miso = miso_q & ~_select;

endmodule

/* design/byte_bus_bridge.sv */
// Widens SPI byte accesses to the 16-bit register bus and narrows read data.
`timescale 1ns/1ps
`include "sound_defs.svh"

module byte_bus_bridge (
  input  logic                  clk,
  input  logic                  _reset,
  input  logic                  byte_rd,
  input  logic                  byte_wr,
  input  sound_pkg::byte_addr_t byte_addr,
  input  sound_pkg::byte_t      byte_wdata,
  output sound_pkg::byte_t      byte_rdata,
  output sound_pkg::bus_req_t   req,
  input  sound_pkg::reg_word_t  reg_rdata
);

  // Lane of the read in flight.
  logic rd_lane;

  //////////////////////////////////////////////////////////////////////
  // Request path, purely combinational.
  //////////////////////////////////////////////////////////////////////

  // Strobes pass straight through.
  assign req.rd = byte_rd;
  assign req.wr = byte_wr;

  // Word address is the byte address shifted down by one.
  assign req.addr = byte_addr[`SND_ADDR_WIDTH-1:1];

  // Odd bytes live in the upper lane.
  assign req.be = byte_addr[0] ? 2'b10 : 2'b01;

  // Same byte on both lanes; the enable picks one.
  assign req.wdata = {byte_wdata, byte_wdata};

  //////////////////////////////////////////////////////////////////////
  // Read return path.
  //////////////////////////////////////////////////////////////////////

  // Register data comes back one cycle after rd, so hold the lane.
  always_ff @(posedge clk) begin
    if (!_reset)
      rd_lane <= 1'b0;
    else if (byte_rd)
      rd_lane <= byte_addr[0];
  end

  // Select the upper or lower byte.
  assign byte_rdata = rd_lane ? reg_rdata[2*`SND_BYTE_WIDTH-1:`SND_BYTE_WIDTH]
                              : reg_rdata[`SND_BYTE_WIDTH-1:0];

endmodule

/* design/sound_regs.sv */
// Sound register bank: control, prescaler and half periods, plus the prescale tick.
`timescale 1ns/1ps
`include "sound_defs.svh"

module sound_regs (
  input  logic                                        clk,
  input  logic                                        _reset,
  input  sound_pkg::bus_req_t                         req,
  output sound_pkg::reg_word_t                        reg_rdata,
  output logic                                        tick,
  output logic [`SND_NUM_CHANNELS-1:0]                ch_enable,
  output sound_pkg::reg_word_t [`SND_NUM_CHANNELS-1:0] ch_half,
  output logic [`SND_NUM_CHANNELS-1:0]                pan_left,
  output logic [`SND_NUM_CHANNELS-1:0]                pan_right
);

  sound_pkg::reg_word_t ctrl;
  sound_pkg::reg_word_t prescale;
  sound_pkg::reg_word_t presc_cnt;
  sound_pkg::reg_word_t rd_mux;
  // Per-bit write mask from the byte enables.
  sound_pkg::reg_word_t wr_mask;

  assign wr_mask = {{`SND_BYTE_WIDTH{req.be[1]}}, {`SND_BYTE_WIDTH{req.be[0]}}};

  //////////////////////////////////////////////////////////////////////
  // Register writes.
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!_reset) begin
      ctrl     <= '0;
      prescale <= '0;
      ch_half  <= '0;
    end else if (req.wr) begin
      if (req.addr == sound_pkg::word_addr_t'(`SND_REG_CTRL))
        ctrl <= (ctrl & ~wr_mask) | (req.wdata & wr_mask);
      if (req.addr == sound_pkg::word_addr_t'(`SND_REG_PRESCALE))
        prescale <= (prescale & ~wr_mask) | (req.wdata & wr_mask);
      if (sound_pkg::is_half_reg(req.addr))
        ch_half[sound_pkg::half_index(req.addr)] <=
            (ch_half[sound_pkg::half_index(req.addr)] & ~wr_mask) | (req.wdata & wr_mask);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Register reads, one cycle after rd.
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    // Unmapped words read as zero.
    rd_mux = '0;
    if (req.addr == sound_pkg::word_addr_t'(`SND_REG_CTRL))
      rd_mux = ctrl;
    else if (req.addr == sound_pkg::word_addr_t'(`SND_REG_PRESCALE))
      rd_mux = prescale;
    else if (sound_pkg::is_half_reg(req.addr))
      rd_mux = ch_half[sound_pkg::half_index(req.addr)];
  end

  always_ff @(posedge clk) begin
    if (!_reset)
      reg_rdata <= '0;
    else if (req.rd)
      reg_rdata <= rd_mux;
  end

  // Prescaler: one tick every prescale + 1 cycles.
  always_ff @(posedge clk) begin
    if (!_reset) begin
      presc_cnt <= '0;
      tick      <= 1'b0;
    end else if (presc_cnt >= prescale) begin
      presc_cnt <= '0;
      tick      <= 1'b1;
    end else begin
      presc_cnt <= presc_cnt + 16'd1;
      tick      <= 1'b0;
    end
  end

  // Control fields.
  assign ch_enable = ctrl[`SND_NUM_CHANNELS-1:0];
  assign pan_left  = ctrl[2*`SND_NUM_CHANNELS-1:`SND_NUM_CHANNELS];
  assign pan_right = ctrl[3*`SND_NUM_CHANNELS-1:2*`SND_NUM_CHANNELS];

endmodule

/* design/tone_channel.sv */
// Square-wave tone generator driven by the shared prescale tick.
`timescale 1ns/1ps

module tone_channel (
  input  logic                 clk,
  input  logic                 _reset,
  input  logic                 tick,
  input  logic                 enable,
  input  sound_pkg::reg_word_t half_period,
  output logic                 wave
);

  // Ticks counted in the current half period.
  sound_pkg::reg_word_t cnt;
  logic                 active;
  logic                 half_done;

  // A zero half period silences the channel.
  assign active = enable & (half_period != '0);

  // Last tick of this half period.
  // Also catches a half period shortened below the count.
  assign half_done = (cnt >= half_period - 16'd1);

  always_ff @(posedge clk) begin
    if (!_reset) begin
      cnt  <= '0;
      wave <= 1'b0;
    end else if (!active) begin
      // Idle: restart from a low level.
      cnt  <= '0;
      wave <= 1'b0;
    end else if (tick) begin
      if (half_done) begin
        cnt  <= '0;
        wave <= ~wave;
      end else begin
        cnt <= cnt + 16'd1;
      end
    end
  end

endmodule

/* design/audio_mixer.sv */
// Sums panned channel waves per side and drives two 1-bit PWM outputs.
`timescale 1ns/1ps
`include "sound_defs.svh"

module audio_mixer (
  input  logic                         clk,
  input  logic                         _reset,
  input  logic [`SND_NUM_CHANNELS-1:0] wave,
  input  logic [`SND_NUM_CHANNELS-1:0] pan_left,
  input  logic [`SND_NUM_CHANNELS-1:0] pan_right,
  output logic                         audio_l,
  output logic                         audio_r
);

  sound_pkg::mix_level_t sum_l;
  sound_pkg::mix_level_t sum_r;
  sound_pkg::mix_level_t level_l;
  sound_pkg::mix_level_t level_r;
  sound_pkg::mix_level_t pwm_cnt;

  // Count active waves routed to each side.
  always_comb begin
    sum_l = '0;
    sum_r = '0;
    for (int k = 0; k < `SND_NUM_CHANNELS; k++) begin
      sum_l = sum_l + sound_pkg::mix_level_t'(wave[k] & pan_left[k]);
      sum_r = sum_r + sound_pkg::mix_level_t'(wave[k] & pan_right[k]);
    end
  end

  // Registered levels and a PWM counter modulo the channel count.
  always_ff @(posedge clk) begin
    if (!_reset) begin
      level_l <= '0;
      level_r <= '0;
      pwm_cnt <= '0;
    end else begin
      level_l <= sum_l;
      level_r <= sum_r;
      if (pwm_cnt == sound_pkg::mix_level_t'(`SND_NUM_CHANNELS - 1))
        pwm_cnt <= '0;
      else
        pwm_cnt <= pwm_cnt + 3'd1;
    end
  end

  // Duty cycle is level out of the channel count.
  assign audio_l = (pwm_cnt < level_l);
  assign audio_r = (pwm_cnt < level_r);

endmodule

/* design/sound_unit_top.sv */
// Sound unit top: SPI host port, register bus, tone channels and PWM mixer.
`timescale 1ns/1ps
`include "sound_defs.svh"

module sound_unit_top (
  input  logic clk,
  input  logic _reset,
  input  logic _select,
  input  logic sck,
  input  logic mosi,
  output logic miso,
  output logic audio_l,
  output logic audio_r
);

  // SPI slave to bridge.
  logic                  byte_rd;
  logic                  byte_wr;
  sound_pkg::byte_addr_t byte_addr;
  sound_pkg::byte_t      byte_wdata;
  sound_pkg::byte_t      byte_rdata;

  // Register bus.
  sound_pkg::bus_req_t   req;
  sound_pkg::reg_word_t  reg_rdata;

  // Register bank to channels and mixer.
  logic                                         tick;
  logic [`SND_NUM_CHANNELS-1:0]                 ch_enable;
  sound_pkg::reg_word_t [`SND_NUM_CHANNELS-1:0] ch_half;
  logic [`SND_NUM_CHANNELS-1:0]                 pan_left;
  logic [`SND_NUM_CHANNELS-1:0]                 pan_right;
  logic [`SND_NUM_CHANNELS-1:0]                 ch_wave;

  //////////////////////////////////////////////////////////////////////
  // Host access path.
  //////////////////////////////////////////////////////////////////////
  spi_mem_slave spi_i (
    .clk(clk), ._reset(_reset),
    ._select(_select), .sck(sck), .mosi(mosi), .miso(miso),
    .byte_rd(byte_rd), .byte_wr(byte_wr), .byte_addr(byte_addr),
    .byte_wdata(byte_wdata), .byte_rdata(byte_rdata)
  );

  byte_bus_bridge bridge_i (
    .clk(clk), ._reset(_reset),
    .byte_rd(byte_rd), .byte_wr(byte_wr), .byte_addr(byte_addr),
    .byte_wdata(byte_wdata), .byte_rdata(byte_rdata),
    .req(req), .reg_rdata(reg_rdata)
  );

  sound_regs regs_i (
    .clk(clk), ._reset(_reset), .req(req), .reg_rdata(reg_rdata),
    .tick(tick), .ch_enable(ch_enable), .ch_half(ch_half),
    .pan_left(pan_left), .pan_right(pan_right)
  );

  // One tone generator per channel.
  for (genvar k = 0; k < `SND_NUM_CHANNELS; k++) begin : g_chan
    tone_channel chan_i (
      .clk(clk), ._reset(_reset), .tick(tick),
      .enable(ch_enable[k]), .half_period(ch_half[k]), .wave(ch_wave[k])
    );
  end

  audio_mixer mixer_i (
    .clk(clk), ._reset(_reset), .wave(ch_wave),
    .pan_left(pan_left), .pan_right(pan_right),
    .audio_l(audio_l), .audio_r(audio_r)
  );

endmodule

/* verif/sound_unit_props.sv */
// Bound checks on the register bus strobes, the read return path and the SPI output.
`timescale 1ns/1ps

module sound_unit_props (
  input logic                  clk,
  input logic                  _reset,
  input logic                  _select,
  input logic                  miso,
  input logic                  byte_rd,
  input sound_pkg::byte_addr_t byte_addr,
  input sound_pkg::byte_t      byte_rdata,
  input sound_pkg::bus_req_t   req,
  input sound_pkg::reg_word_t  reg_rdata
);

  // Read and write never share a cycle on the register bus.
  a_no_rd_wr: assert property (@(posedge clk) disable iff (!_reset)
    !(req.rd && req.wr))
    else $error("rd and wr high in the same cycle");

  // One cycle later the addressed lane of the returned word is on byte_rdata.
  a_rd_return: assert property (@(posedge clk) disable iff (!_reset)
    byte_rd |=> (byte_rdata == ($past(byte_addr[0]) ? reg_rdata[15:8] : reg_rdata[7:0])))
    else $error("read byte not returned one cycle after byte_rd");

  // miso is quiet while the host is not selecting us.
  a_miso_idle: assert property (@(posedge clk) disable iff (!_reset)
    _select |-> !miso)
    else $error("miso driven while deselected");

endmodule

/* verif/sound_unit_tb.sv */
// Testbench for the sound unit: SPI register access and PWM tone output checks.
`timescale 1ns/1ps

module sound_unit_tb;

  // Character codes seen by the stimulus parser.
  localparam int CH_TAB   = 9;
  localparam int CH_LF    = 10;
  localparam int CH_CR    = 13;
  localparam int CH_SPACE = 32;
  localparam int CH_HASH  = 35;
  localparam int CH_R     = 114;
  localparam int CH_T     = 116;
  localparam int CH_W     = 119;

  // Allowed error on a tone period, in clk cycles.
  localparam int PERIOD_TOL = 4;
  // Low run on audio_l longer than a PWM frame, so a new burst follows.
  localparam int BURST_GAP = 6;
  // Cycles watched when both outputs must stay low.
  localparam int SILENCE_WINDOW = 1000;

  logic clk;
  logic _reset;
  logic _select;
  logic sck;
  logic mosi;
  logic miso;
  logic audio_l;
  logic audio_r;

  // Data bytes of the current stimulus line.
  logic [7:0] burst_bytes [0:127];

  sound_unit_top sound_unit_top_i (
    .clk(clk), ._reset(_reset),
    ._select(_select), .sck(sck), .mosi(mosi), .miso(miso),
    .audio_l(audio_l), .audio_r(audio_r)
  );

  bind sound_unit_top sound_unit_props props_i (
    .clk(clk), ._reset(_reset), ._select(_select), .miso(miso),
    .byte_rd(byte_rd), .byte_addr(byte_addr), .byte_rdata(byte_rdata),
    .req(req), .reg_rdata(reg_rdata)
  );

  // 20 ns clock.
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reporting.
  //////////////////////////////////////////////////////////////////////
  task automatic fail_run(input string msg);
    $display("[ERROR] time %0d ns: %s", $time, msg);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input int actual, input int expected, input string what);
    if (actual != expected)
      fail_run($sformatf("%s: got %0d, expected %0d", what, actual, expected));
  endtask

  //////////////////////////////////////////////////////////////////////
  // SPI host, mode 0, sck at 1/10 of clk.
  //////////////////////////////////////////////////////////////////////

  // One bit: 5 cycles low, 5 high. miso is sampled just before the rise.
  task automatic spi_bit(input logic out_bit, output logic in_bit);
    @(posedge clk);
    sck  <= 1'b0;
    mosi <= out_bit;
    repeat (4) @(posedge clk);
    @(negedge clk);
    in_bit = miso;
    @(posedge clk);
    sck <= 1'b1;
    repeat (4) @(posedge clk);
  endtask

  // MSB first.
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    logic b;
    for (int i = 7; i >= 0; i--) begin
      spi_bit(tx[i], b);
      rx[i] = b;
    end
  endtask

  task automatic spi_select();
    @(posedge clk);
    _select <= 1'b0;
    // Let the slave see the select before the first edge.
    repeat (3) @(posedge clk);
  endtask

  // Park sck low, then leave room for the last strobe before deselecting.
  task automatic spi_deselect();
    @(posedge clk);
    sck <= 1'b0;
    repeat (5) @(posedge clk);
    _select <= 1'b1;
    repeat (4) @(posedge clk);
  endtask

  // Burst write of burst_bytes[0 .. count-1] from addr upward.
  task automatic spi_write(input logic [6:0] addr, input int count);
    logic [7:0] rx;
    spi_select();
    spi_byte({1'b1, addr}, rx);
    for (int i = 0; i < count; i++)
      spi_byte(burst_bytes[i], rx);
    spi_deselect();
  endtask

  // Burst read from addr upward, each byte checked against burst_bytes.
  task automatic spi_read_check(input logic [6:0] addr, input int count);
    logic [7:0] rx;
    logic [6:0] at;
    spi_select();
    // Nothing useful comes back during the command byte.
    spi_byte({1'b0, addr}, rx);
    for (int i = 0; i < count; i++) begin
      spi_byte(8'h00, rx);
      at = addr + 7'(i);
      check_value(int'(rx), int'(burst_bytes[i]), $sformatf("read of byte 'h%02h", at));
    end
    spi_deselect();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Audio measurement.
  //////////////////////////////////////////////////////////////////////

  // Spacing of burst starts on audio_l; audio_r must stay low.
  task automatic measure_tone(input int period);
    int starts [0:3];
    int found;
    int low_run;
    int cycle;
    int limit;
    int diff;
    found   = 0;
    low_run = 0;
    cycle   = 0;
    limit   = 5 * period + 200;
    while (found < 4) begin
      @(negedge clk);
      cycle++;
      if (cycle > limit)
        fail_run("timed out waiting for a tone burst on audio_l");
      check_value(int'(audio_r), 0, "audio_r during a left-panned tone");
      if (audio_l) begin
        if (low_run >= BURST_GAP) begin
          starts[found] = cycle;
          found++;
        end
        low_run = 0;
      end else begin
        low_run++;
      end
    end
    // First start may straddle the register update, so it only anchors.
    for (int i = 2; i < 4; i++) begin
      diff = starts[i] - starts[i-1];
      if (diff < period - PERIOD_TOL || diff > period + PERIOD_TOL)
        check_value(diff, period, "audio_l burst spacing in cycles");
    end
  endtask

  task automatic check_silence(input int window);
    for (int i = 0; i < window; i++) begin
      @(negedge clk);
      check_value(int'(audio_l), 0, "audio_l on a silent channel");
      check_value(int'(audio_r), 0, "audio_r on a silent channel");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus file parser.
  //////////////////////////////////////////////////////////////////////
  task automatic run_stimulus();
    int         fd;
    int         ch;
    int         code;
    int         count;
    int         period;
    int         ops;
    logic [7:0] addr;
    ops = 0;
    fd  = $fopen("verif/sound_unit_stim.txt", "r");
    if (fd == 0)
      fail_run("cannot open verif/sound_unit_stim.txt");
    ch = $fgetc(fd);
    while (ch != -1) begin
      if (ch == CH_SPACE || ch == CH_LF || ch == CH_CR || ch == CH_TAB) begin
        ch = $fgetc(fd);
      end else if (ch == CH_HASH) begin
        // Comment runs to the end of the line.
        while (ch != -1 && ch != CH_LF)
          ch = $fgetc(fd);
      end else if (ch == CH_W || ch == CH_R) begin
        code = $fscanf(fd, "%h %d", addr, count);
        if (code != 2 || count < 1 || count > 128)
          fail_run("malformed access line in the stimulus file");
        for (int i = 0; i < count; i++) begin
          code = $fscanf(fd, "%h", burst_bytes[i]);
          if (code != 1)
            fail_run("missing data byte in the stimulus file");
        end
        if (ch == CH_W)
          spi_write(addr[6:0], count);
        else
          spi_read_check(addr[6:0], count);
        ops++;
        ch = $fgetc(fd);
      end else if (ch == CH_T) begin
        code = $fscanf(fd, "%d", period);
        if (code != 1)
          fail_run("malformed tone line in the stimulus file");
        // Zero period means the channel must be silent.
        if (period == 0)
          check_silence(SILENCE_WINDOW);
        else
          measure_tone(period);
        ops++;
        ch = $fgetc(fd);
      end else begin
        fail_run($sformatf("unknown operation '%c' in the stimulus file", ch));
      end
    end
    $fclose(fd);
    if (ops == 0)
      fail_run("stimulus file held no operations");
  endtask

  // Main sequence.
  initial begin
    _reset  = 1'b0;
    _select = 1'b1;
    sck     = 1'b0;
    mosi    = 1'b0;
    repeat (8) @(posedge clk);
    _reset <= 1'b1;
    repeat (4) @(posedge clk);
    run_stimulus();
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* compile.f */
+incdir+design
design/sound_pkg.sv
design/spi_mem_slave.sv
design/byte_bus_bridge.sv
design/sound_regs.sv
design/tone_channel.sv
design/audio_mixer.sv
design/sound_unit_top.sv
verif/sound_unit_props.sv
verif/sound_unit_tb.sv

/* Makefile */
# Verilator build and run for the sound unit testbench.

VERILATOR ?= verilator
SIM_TOP   ?= sound_unit_tb
VFLAGS    ?= --binary --timing --assert
OBJ_DIR   ?= obj_dir

SIM_BIN := $(OBJ_DIR)/V$(SIM_TOP)
SOURCES := compile.f $(wildcard design/*.sv design/*.svh verif/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuild only when a source or the file list changes.
$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(SIM_TOP) --Mdir $(OBJ_DIR) -f compile.f

# The stimulus path is relative to the project root.
run: $(SIM_BIN)
	$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* verif/sound_unit_stim.txt */
# Columns: op, byte address (hex), byte count (dec), then that many bytes (hex).
# w writes the bytes, r reads and expects them; t <cycles>: audio_l period, 0 = silent.
r 00 12 00 00 00 00 00 00 00 00 00 00 00 00
w 02 1 5a
r 02 1 5a
w 03 1 c3
r 02 2 5a c3
w 05 1 7e
r 04 2 00 7e
w 04 1 81
r 04 2 81 7e
w 00 16 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff 01
r 00 16 11 22 33 44 55 66 77 88 99 aa bb cc 00 00 00 00
r 03 4 44 55 66 77
r 7e 2 00 00
w 00 2 00 00
w 02 4 03 00 05 00
w 00 1 11
t 40
w 00 1 00
w 02 1 01
w 04 1 0c
w 00 1 11
t 48
w 00 1 10
t 0
w 04 2 00 00
w 00 1 11
t 0
